//--- include/regfile_defines.svh
`ifndef REGFILE_DEFINES_SVH
`define REGFILE_DEFINES_SVH

// ======================================================================
// Register file sizing
// ======================================================================

// Number of physical registers held by the file
// Register 0 is hardwired to zero and is never stored
`define RF_NREGS 32

// Number of write ports
// Each write port owns a bank of its own, so this is also the bank count
`define RF_WPORTS 2

// Number of read ports
// Every bank keeps one memory copy per read port
`define RF_RPORTS 3

// ======================================================================
// Entry layout
// ======================================================================

// Width of the data value held in one register
`define RF_VALUE_W 32

// Width of the flags tag stored next to the value
`define RF_FLAGS_W 8

`endif

//--- verilog/regfile_pkg.sv
`default_nettype none
`include "regfile_defines.svh"

// Types shared by the register file and its testbench
package regfile_pkg;

	// ======================================================================
	// Basic fields
	// ======================================================================

	// Physical register number
	typedef logic [$clog2(`RF_NREGS)-1:0] preg_t;

	// Register value and the flags tag that travels with it
	typedef logic [`RF_VALUE_W-1:0] value_t;
	typedef logic [`RF_FLAGS_W-1:0] flags_t;

	// One stored entry, flags in the upper bits
	typedef struct packed {
		flags_t flags;
		value_t value;
	} rf_entry_t;

	// Index of a bank, which is the same as the index of its write port
	typedef logic [$clog2(`RF_WPORTS)-1:0] bank_sel_t;

	// ======================================================================
	// Port structs
	// ======================================================================

	// Write request, always a full entry
	typedef struct packed {
		logic      valid;
		preg_t     preg;
		rf_entry_t entry;
	} wr_req_t;

	// Read request, only an address is needed
	typedef struct packed {
		logic  valid;
		preg_t preg;
	} rd_req_t;

	// Read response, one cycle after the request
	typedef struct packed {
		logic      valid;
		rf_entry_t entry;
	} rd_rsp_t;

endpackage

`default_nettype wire

//--- verilog/lvt_write_front.sv
`default_nettype none
`include "regfile_defines.svh"

// Write side of the register file
// Keeps the live value table and steers every write to its own bank
module lvt_write_front import regfile_pkg::*; (
	input  wire            clk,
	input  wire            rst,
	input  wire wr_req_t   wr        [`RF_WPORTS],
	input  wire rd_req_t   rd        [`RF_RPORTS],
	output wr_req_t        bank_wr   [`RF_WPORTS],
	output bank_sel_t      live_bank [`RF_RPORTS]
);

	// Live value table
	// One entry per register, naming the bank that holds its newest value
	bank_sel_t lvt [`RF_NREGS];

	// ======================================================================
	// Write filtering
	// ======================================================================

	// Each write port feeds exactly one bank
	// A write to register 0 is passed on with its valid cleared
	always_comb begin
		for (int p = 0; p < `RF_WPORTS; p++) begin
			bank_wr[p] = wr[p];
			if (wr[p].preg == '0)
				bank_wr[p].valid = 1'b0;
		end
	end

	// ======================================================================
	// Live value table update
	// ======================================================================

	// All ports are scanned in rising order inside one process
	// So the highest port that hits a register is the last assignment
	// and wins the entry, matching the bypass priority on the read side
	always_ff @(posedge clk) begin
		if (rst) begin
			// Everything points at bank 0 after reset
			for (int n = 0; n < `RF_NREGS; n++)
				lvt[n] <= '0;
		end else begin
			for (int p = 0; p < `RF_WPORTS; p++) begin
				if (bank_wr[p].valid)
					lvt[bank_wr[p].preg] <= bank_sel_t'(p);
			end
		end
	end

	// ======================================================================
	// Bank choice per read port
	// ======================================================================

	// The table is sampled before this edge's writes land
	// That lines up with the banks, which also return old data at the edge
	// A write at the same edge is caught by the bypass in read_select
	always_ff @(posedge clk) begin
		for (int r = 0; r < `RF_RPORTS; r++) begin
			if (rst)
				live_bank[r] <= '0;
			else if (rd[r].valid)
				// Only loaded for a real read, the last choice is held otherwise
				live_bank[r] <= lvt[rd[r].preg];
		end
	end

endmodule

`default_nettype wire

//--- verilog/regfile_bank.sv
`default_nettype none
`include "regfile_defines.svh"

// One bank of the register file
// A bank has a single write port and a full set of read ports, built by
// keeping one simple dual-port memory copy per read port
module regfile_bank import regfile_pkg::*; (
	input  wire              clk,
	input  wire wr_req_t     wr,
	input  wire preg_t       raddr [`RF_RPORTS],
	output rf_entry_t        rdata [`RF_RPORTS]
);

	// ======================================================================
	// Replicated memory
	// ======================================================================

	genvar r;

	for (r = 0; r < `RF_RPORTS; r++) begin : g_copy

		// Storage for this read port
		// Every copy sees the same write so the copies never diverge
		rf_entry_t mem [`RF_NREGS];

		// Write and read share the edge
		// The read returns the contents from before the write, one
		// cycle of latency, which is what block RAM gives in read-first mode
		always_ff @(posedge clk) begin
			if (wr.valid)
				mem[wr.preg] <= wr.entry;
			rdata[r] <= mem[raddr[r]];
		end

	end

endmodule

`default_nettype wire

//--- verilog/read_select.sv
`default_nettype none
`include "regfile_defines.svh"

// Read side of the register file
// Picks the live bank per read port, with same-cycle write bypass on top
module read_select import regfile_pkg::*; (
	input  wire             clk,
	input  wire             rst,
	input  wire rd_req_t    rd        [`RF_RPORTS],
	input  wire wr_req_t    wr        [`RF_WPORTS],
	input  wire rf_entry_t  bank_data [`RF_WPORTS][`RF_RPORTS],
	input  wire bank_sel_t  live_bank [`RF_RPORTS],
	output rd_rsp_t         rsp       [`RF_RPORTS]
);

	// Bypass candidates found in the request cycle
	logic      hit_d [`RF_RPORTS];
	rf_entry_t byp_d [`RF_RPORTS];

	// State carried into the response cycle
	logic      vld_q  [`RF_RPORTS];
	logic      zero_q [`RF_RPORTS];
	logic      hit_q  [`RF_RPORTS];
	rf_entry_t byp_q  [`RF_RPORTS];

	// ======================================================================
	// Same-cycle write match
	// ======================================================================

	// The banks and the LVT both miss a write taken at the read's own edge,
	// so that write is compared here against the read address
	// Scanning upward makes the highest matching port the one kept
	always_comb begin
		for (int r = 0; r < `RF_RPORTS; r++) begin
			hit_d[r] = 1'b0;
			byp_d[r] = '0;
			for (int p = 0; p < `RF_WPORTS; p++) begin
				if (wr[p].valid && wr[p].preg == rd[r].preg) begin
					hit_d[r] = 1'b1;
					byp_d[r] = wr[p].entry;
				end
			end
		end
	end

	// ======================================================================
	// Request registers
	// ======================================================================

	// Valid, zero detect and hit line up with the bank read latency
	always_ff @(posedge clk) begin
		for (int r = 0; r < `RF_RPORTS; r++) begin
			if (rst) begin
				vld_q[r]  <= 1'b0;
				zero_q[r] <= 1'b0;
				hit_q[r]  <= 1'b0;
			end else begin
				vld_q[r]  <= rd[r].valid;
				zero_q[r] <= (rd[r].preg == '0);
				hit_q[r]  <= hit_d[r];
			end
		end
	end

	// Bypass payload
	always_ff @(posedge clk) begin
		for (int r = 0; r < `RF_RPORTS; r++)
			byp_q[r] <= byp_d[r];
	end

	// ======================================================================
	// Response mux
	// ======================================================================

	// Register 0 beats everything, then bypass, then the live bank
	always_comb begin
		for (int r = 0; r < `RF_RPORTS; r++) begin
			rsp[r].valid = vld_q[r];
			if (zero_q[r])
				rsp[r].entry = '0;
			else if (hit_q[r])
				rsp[r].entry = byp_q[r];
			else
				rsp[r].entry = bank_data[live_bank[r]][r];
		end
	end

endmodule

`default_nettype wire

//--- verilog/regfile_top.sv
`default_nettype none
`include "regfile_defines.svh"

// Multi-ported physical register file
// Built from one bank per write port and a live value table that
// remembers which bank holds the newest copy of each register
module regfile_top import regfile_pkg::*; (
	input  wire             clk,
	input  wire             rst,
	input  wire wr_req_t    wr  [`RF_WPORTS],
	input  wire rd_req_t    rd  [`RF_RPORTS],
	output rd_rsp_t         rsp [`RF_RPORTS]
);

	// Filtered writes, one per bank
	wr_req_t   bank_wr   [`RF_WPORTS];

	// Bank that held each read's register when the read was issued
	bank_sel_t live_bank [`RF_RPORTS];

	// Read addresses fanned out to every bank
	preg_t     raddr     [`RF_RPORTS];

	// Entries returned by every bank for every read port
	rf_entry_t bank_data [`RF_WPORTS][`RF_RPORTS];

	genvar b;
	genvar r;

	// ======================================================================
	// Write front end
	// ======================================================================

	lvt_write_front u_front (
		.clk       (clk),
		.rst       (rst),
		.wr        (wr),
		.rd        (rd),
		.bank_wr   (bank_wr),
		.live_bank (live_bank)
	);

	// ======================================================================
	// Banks
	// ======================================================================

	// The banks only need the address part of each read request
	for (r = 0; r < `RF_RPORTS; r++) begin : g_raddr
		assign raddr[r] = rd[r].preg;
	end

	// Bank b is written only by write port b
	for (b = 0; b < `RF_WPORTS; b++) begin : g_bank
		regfile_bank u_bank (
			.clk   (clk),
			.wr    (bank_wr[b]),
			.raddr (raddr),
			.rdata (bank_data[b])
		);
	end

	// ======================================================================
	// Read selection
	// ======================================================================

	read_select u_select (
		.clk       (clk),
		.rst       (rst),
		.rd        (rd),
		.wr        (wr),
		.bank_data (bank_data),
		.live_bank (live_bank),
		.rsp       (rsp)
	);

endmodule

`default_nettype wire

//--- test/regfile_chk.sv
`default_nettype none
`include "regfile_defines.svh"

// Protocol checker bound onto the register file top level
module regfile_chk import regfile_pkg::*; (
	input wire          clk,
	input wire          rst,
	input wire rd_req_t rd  [`RF_RPORTS],
	input wire rd_rsp_t rsp [`RF_RPORTS]
);

	// Number of assertion failures seen so far
	int fail_count = 0;

	genvar r;

	// ======================================================================
	// Per read port properties
	// ======================================================================

	for (r = 0; r < `RF_RPORTS; r++) begin : g_port

		// A request always gets its response on the very next cycle
		a_rsp_follows: assert property (@(posedge clk) disable iff (rst)
			rd[r].valid |=> rsp[r].valid)
		else begin
			$error("port %0d request got no response one cycle later", r);
			fail_count++;
		end

		// And no response turns up without a request before it
		a_no_stray: assert property (@(posedge clk) disable iff (rst)
			!rd[r].valid |=> !rsp[r].valid)
		else begin
			$error("port %0d response valid without a request", r);
			fail_count++;
		end

		// Register 0 is hardwired to zero, flags too
		a_zero_reg: assert property (@(posedge clk) disable iff (rst)
			(rd[r].valid && rd[r].preg == '0) |=> (rsp[r].entry == '0))
		else begin
			$error("port %0d read of register 0 returned nonzero data", r);
			fail_count++;
		end

		// Reset clears the response pipeline
		a_reset_quiet: assert property (@(posedge clk)
			rst |=> !rsp[r].valid)
		else begin
			$error("port %0d response valid during or right after reset", r);
			fail_count++;
		end

	end

endmodule

`default_nettype wire

//--- test/regfile_tb.sv
`default_nettype none
`include "regfile_defines.svh"

// Testbench for the multi-ported register file
// Every cycle of stimulus and the responses it should produce come from a data file
module regfile_tb import regfile_pkg::*; ();

	localparam int MAX_LINES    = 64;
	localparam int RESET_CYCLES = 5;
	localparam int SLACK_CYCLES = 20;
	localparam int FIELDS       = 20;

	logic    clk;
	logic    rst;
	wr_req_t wr  [`RF_WPORTS];
	rd_req_t rd  [`RF_RPORTS];
	rd_rsp_t rsp [`RF_RPORTS];

	// One row per data line holds what to drive and what should come back a cycle later
	wr_req_t   line_wr  [MAX_LINES][`RF_WPORTS];
	rd_req_t   line_rd  [MAX_LINES][`RF_RPORTS];
	rf_entry_t line_exp [MAX_LINES][`RF_RPORTS];
	int        n_lines = 0;

	// Lines whose responses are still due
	int pending [$];

	// Run length guard
	int cycles      = 0;
	int cycle_limit = 0;

	// ======================================================================
	// Clock, DUT and checker
	// ======================================================================

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	regfile_top dut (
		.clk (clk),
		.rst (rst),
		.wr  (wr),
		.rd  (rd),
		.rsp (rsp)
	);

	// Port protocol assertions live inside the DUT scope
	bind regfile_top regfile_chk u_chk (
		.clk (clk),
		.rst (rst),
		.rd  (rd),
		.rsp (rsp)
	);

	// ======================================================================
	// Helpers
	// ======================================================================

	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	// Each line holds two writes of four fields, three reads of two and three expected pairs
	task automatic load_input();
		int          fd;
		int          got;
		string       line;
		logic [31:0] f [FIELDS];
		fd = $fopen("test/regfile_input.txt", "r");
		if (fd == 0)
			stop_with_error("could not open the stimulus file test/regfile_input.txt");
		while ($fgets(line, fd) != 0) begin
			// Comment and blank lines carry no cycle
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			if (n_lines >= MAX_LINES)
				stop_with_error("the stimulus file has more lines than the testbench holds");
			got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
				f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
			if (got != FIELDS)
				stop_with_error($sformatf("stimulus line %0d has %0d fields, not %0d",
					n_lines + 1, got, FIELDS));
			for (int p = 0; p < `RF_WPORTS; p++) begin
				line_wr[n_lines][p].valid       = f[4*p][0];
				line_wr[n_lines][p].preg        = preg_t'(f[4*p+1]);
				line_wr[n_lines][p].entry.flags = flags_t'(f[4*p+2]);
				line_wr[n_lines][p].entry.value = value_t'(f[4*p+3]);
			end
			for (int r = 0; r < `RF_RPORTS; r++) begin
				line_rd[n_lines][r].valid        = f[8+2*r][0];
				line_rd[n_lines][r].preg         = preg_t'(f[9+2*r]);
				line_exp[n_lines][r].flags       = flags_t'(f[14+2*r]);
				line_exp[n_lines][r].value       = value_t'(f[15+2*r]);
			end
			n_lines++;
		end
		$fclose(fd);
		if (n_lines == 0)
			stop_with_error("the stimulus file holds no cycles");
	endtask

	task automatic idle_inputs();
		for (int p = 0; p < `RF_WPORTS; p++)
			wr[p] = '0;
		for (int r = 0; r < `RF_RPORTS; r++)
			rd[r] = '0;
	endtask

	task automatic drive_line(input int idx);
		for (int p = 0; p < `RF_WPORTS; p++)
			wr[p] = line_wr[idx][p];
		for (int r = 0; r < `RF_RPORTS; r++)
			rd[r] = line_rd[idx][r];
	endtask

	// One response port against its expected entry
	task automatic check_rsp(input rd_rsp_t got, input logic exp_valid,
	                         input rf_entry_t exp, input int port);
		if (exp_valid && got.valid !== 1'b1)
			stop_with_error($sformatf("read port %0d gave no response at time %0t",
				port, $time));
		else if (!exp_valid && got.valid !== 1'b0)
			stop_with_error($sformatf("read port %0d gave an unrequested response at time %0t",
				port, $time));
		else if (exp_valid && got.entry !== exp)
			stop_with_error($sformatf(
				"MISMATCH time %0t rsp[%0d].entry got %h_%h expected %h_%h",
				$time, port, got.entry.flags, got.entry.value, exp.flags, exp.value));
	endtask

	// Responses to the oldest queued line are due now
	task automatic check_pending();
		int idx;
		idx = pending.pop_front();
		for (int r = 0; r < `RF_RPORTS; r++)
			check_rsp(rsp[r], line_rd[idx][r].valid, line_exp[idx][r], r);
		if (dut.u_chk.fail_count != 0)
			stop_with_error("a port protocol assertion fired");
	endtask

	// ======================================================================
	// Timeout
	// ======================================================================

	initial begin
		wait (cycle_limit > 0);
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles >= cycle_limit)
				stop_with_error($sformatf("the run did not finish within %0d cycles",
					cycle_limit));
		end
	end

	// ======================================================================
	// Main sequence
	// ======================================================================

	initial begin
		rst = 1'b1;
		idle_inputs();
		load_input();
		cycle_limit = n_lines + RESET_CYCLES + SLACK_CYCLES;

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;

		// Each line is driven just after one edge and its responses are checked just after the next
		for (int i = 0; i < n_lines; i++) begin
			drive_line(i);
			pending.push_back(i);
			@(posedge clk);
			#1;
			check_pending();
		end
		idle_inputs();

		@(posedge clk);
		#1;
		if (dut.u_chk.fail_count != 0) begin
			stop_with_error("a port protocol assertion fired at the end of the run");
		end else begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- test/regfile_input.txt
# wp0 v reg flags value, wp1 v reg flags value, rp0..rp2 v reg
# then expected flags value for rp0, rp1, rp2 one cycle later, all hex
1 05 a1 11110005 0 00 00 00000000 0 00 0 00 0 00 00 00000000 00 00000000 00 00000000
0 00 00 00000000 0 00 00 00000000 0 00 0 00 0 00 00 00000000 00 00000000 00 00000000
0 00 00 00000000 0 00 00 00000000 1 05 1 05 1 05 a1 11110005 a1 11110005 a1 11110005
1 08 c3 33330008 1 07 b2 22220007 0 00 0 00 0 00 00 00000000 00 00000000 00 00000000
0 00 00 00000000 0 00 00 00000000 1 07 1 08 1 05 b2 22220007 c3 33330008 a1 11110005
1 09 01 90000001 0 00 00 00000000 0 00 0 00 0 00 00 00000000 00 00000000 00 00000000
0 00 00 00000000 0 00 00 00000000 1 09 1 09 1 09 01 90000001 01 90000001 01 90000001
0 00 00 00000000 1 09 02 90000002 0 00 0 00 0 00 00 00000000 00 00000000 00 00000000
0 00 00 00000000 0 00 00 00000000 1 09 1 09 1 09 02 90000002 02 90000002 02 90000002
1 09 03 90000003 0 00 00 00000000 0 00 0 00 0 00 00 00000000 00 00000000 00 00000000
0 00 00 00000000 0 00 00 00000000 1 09 1 09 1 09 03 90000003 03 90000003 03 90000003
0 00 00 00000000 1 09 04 90000004 1 05 0 00 1 09 a1 11110005 00 00000000 04 90000004
0 00 00 00000000 0 00 00 00000000 1 09 1 09 1 09 04 90000004 04 90000004 04 90000004
1 0a 0a aaaa000a 0 00 00 00000000 1 0a 1 0a 1 07 0a aaaa000a 0a aaaa000a b2 22220007
1 0b 10 bbbb0010 1 0b 11 bbbb0011 1 0b 1 0b 1 0b 11 bbbb0011 11 bbbb0011 11 bbbb0011
0 00 00 00000000 0 00 00 00000000 1 0b 1 0b 1 0b 11 bbbb0011 11 bbbb0011 11 bbbb0011
1 0c 20 cccc0020 1 0c 21 cccc0021 0 00 0 00 0 00 00 00000000 00 00000000 00 00000000
0 00 00 00000000 0 00 00 00000000 1 0c 1 0b 1 0a 21 cccc0021 11 bbbb0011 0a aaaa000a
1 00 ff deadbeef 1 00 ee cafef00d 1 00 1 00 1 00 00 00000000 00 00000000 00 00000000
0 00 00 00000000 0 00 00 00000000 1 00 1 00 1 00 00 00000000 00 00000000 00 00000000
0 00 00 00000000 1 00 ff ffffffff 1 05 1 00 0 00 a1 11110005 00 00000000 00 00000000
0 00 00 00000000 0 00 00 00000000 1 05 1 07 1 08 a1 11110005 b2 22220007 c3 33330008
0 00 00 00000000 0 00 00 00000000 1 09 1 0a 1 0b 04 90000004 0a aaaa000a 11 bbbb0011
0 00 00 00000000 0 00 00 00000000 1 0c 1 00 1 09 21 cccc0021 00 00000000 04 90000004
1 0d d0 dddd0013 0 00 00 00000000 1 08 1 0d 1 0c c3 33330008 d0 dddd0013 21 cccc0021
0 00 00 00000000 0 00 00 00000000 1 0d 1 0d 1 0d d0 dddd0013 d0 dddd0013 d0 dddd0013
0 00 00 00000000 0 00 00 00000000 0 00 0 00 0 00 00 00000000 00 00000000 00 00000000

//--- sources.f
+incdir+include
verilog/regfile_pkg.sv
verilog/lvt_write_front.sv
verilog/regfile_bank.sv
verilog/read_select.sv
verilog/regfile_top.sv
test/regfile_chk.sv
test/regfile_tb.sv
